// ==== common/soc_pkg.sv ====
/*
 * Control subsystem package
 * Bus widths, region codes, address map, register offsets and boot ROM image
 */
`default_nettype none

package soc_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;

  // ------------------------------
  // Address map
  // ------------------------------
  typedef enum logic [1:0] {
    RegionDebug = 2'd0,
    RegionRom   = 2'd1,
    RegionClint = 2'd2,
    RegionNone  = 2'd3
  } region_e;

  localparam logic [AddrWidth-1:0] DebugBase   = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] DebugLength = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] RomBase     = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] RomLength   = 32'h0000_1000;
  localparam logic [AddrWidth-1:0] ClintBase   = 32'h0200_0000;
  localparam logic [AddrWidth-1:0] ClintLength = 32'h0000_C000;

  // Rule matches start_addr <= addr < end_addr
  typedef struct packed {
    region_e              idx;
    logic [AddrWidth-1:0] start_addr;
    logic [AddrWidth-1:0] end_addr;
  } addr_rule_t;

  localparam int unsigned NumRules = 3;

  localparam addr_rule_t AddrMap [NumRules] = '{
    '{idx: RegionDebug, start_addr: DebugBase, end_addr: DebugBase + DebugLength},
    '{idx: RegionRom,   start_addr: RomBase,   end_addr: RomBase + RomLength},
    '{idx: RegionClint, start_addr: ClintBase, end_addr: ClintBase + ClintLength}
  };

  // ------------------------------
  // Register offsets
  // ------------------------------
  localparam logic [AddrWidth-1:0] ClintMsipOffset     = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] ClintMtimecmpOffset = 32'h0000_4000;
  localparam logic [AddrWidth-1:0] ClintMtimeOffset    = 32'h0000_BFF8;
  localparam logic [AddrWidth-1:0] DebugHaltreqOffset  = 32'h0000_0000;

  // ------------------------------
  // Boot ROM and tick sync
  // ------------------------------
  localparam int unsigned RomWords = 8;

  localparam logic [DataWidth-1:0] boot_rom_content [RomWords] = '{
    64'h0B00_7000_0000_0000,
    64'h0B00_7000_0000_0001,
    64'h0B00_7000_0000_0002,
    64'h0B00_7000_0000_0003,
    64'h0B00_7000_0000_0004,
    64'h0B00_7000_0000_0005,
    64'h0B00_7000_0000_0006,
    64'h0B00_7000_0000_0007
  };

  localparam int unsigned SyncStages = 3;

endpackage

`default_nettype wire

// ==== design/xbar/periph_xbar.sv ====
/*
 * Peripheral crossbar
 * Decodes requests against the address map and merges target responses
 */
`timescale 1ns/100ps
`default_nettype none

module periph_xbar (
  input  logic                          clk_i,
  input  logic                          ndmreset_n,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::AddrWidth-1:0] addr_i,
  input  logic [soc_pkg::DataWidth-1:0] wdata_i,
  output logic                          rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic                          err_o,
  // Toward targets
  output logic                          dbg_sel_o,
  output logic                          rom_sel_o,
  output logic                          clint_sel_o,
  output logic                          tgt_we_o,
  output logic [soc_pkg::AddrWidth-1:0] tgt_offset_o,
  output logic [soc_pkg::DataWidth-1:0] tgt_wdata_o,
  // From targets
  input  logic                          dbg_rsp_valid_i,
  input  logic [soc_pkg::DataWidth-1:0] dbg_rdata_i,
  input  logic                          dbg_err_i,
  input  logic                          rom_rsp_valid_i,
  input  logic [soc_pkg::DataWidth-1:0] rom_rdata_i,
  input  logic                          rom_err_i,
  input  logic                          clint_rsp_valid_i,
  input  logic [soc_pkg::DataWidth-1:0] clint_rdata_i,
  input  logic                          clint_err_i
);

  soc_pkg::region_e              hit_region;
  logic [soc_pkg::AddrWidth-1:0] hit_base;
  logic                          miss_q1, miss_q2;

  // Last matching rule wins, rules do not overlap
  always_comb begin
    hit_region = soc_pkg::RegionNone;
    hit_base   = '0;
    for (int i = 0; i < soc_pkg::NumRules; i++) begin
      if (addr_i >= soc_pkg::AddrMap[i].start_addr &&
          addr_i <  soc_pkg::AddrMap[i].end_addr) begin
        hit_region = soc_pkg::AddrMap[i].idx;
        hit_base   = soc_pkg::AddrMap[i].start_addr;
      end
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      dbg_sel_o   <= 1'b0;
      rom_sel_o   <= 1'b0;
      clint_sel_o <= 1'b0;
      miss_q1     <= 1'b0;
      miss_q2     <= 1'b0;
    end else begin
      dbg_sel_o   <= req_i && hit_region == soc_pkg::RegionDebug;
      rom_sel_o   <= req_i && hit_region == soc_pkg::RegionRom;
      clint_sel_o <= req_i && hit_region == soc_pkg::RegionClint;
      // No default port, a miss is answered here
      miss_q1     <= req_i && hit_region == soc_pkg::RegionNone;
      miss_q2     <= miss_q1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      tgt_we_o     <= we_i;
      tgt_offset_o <= addr_i - hit_base;
      tgt_wdata_o  <= wdata_i;
    end
  end

  // ------------------------------
  // Response merge
  // ------------------------------
  assign rsp_valid_o = dbg_rsp_valid_i | rom_rsp_valid_i | clint_rsp_valid_i | miss_q2;

  assign rdata_o = ({soc_pkg::DataWidth{dbg_rsp_valid_i}}   & dbg_rdata_i) |
                   ({soc_pkg::DataWidth{rom_rsp_valid_i}}   & rom_rdata_i) |
                   ({soc_pkg::DataWidth{clint_rsp_valid_i}} & clint_rdata_i);

  assign err_o = (dbg_rsp_valid_i & dbg_err_i) | (rom_rsp_valid_i & rom_err_i) |
                 (clint_rsp_valid_i & clint_err_i) | miss_q2;

  // Each target answers exactly one cycle after its own select
  a_rsp_follows_sel : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    {dbg_rsp_valid_i, rom_rsp_valid_i, clint_rsp_valid_i} ==
    $past({dbg_sel_o, rom_sel_o, clint_sel_o}));

endmodule

`default_nettype wire

// ==== design/clint/rtc_tick.sv ====
/*
 * Real-time clock tick generator
 * Halves rtc_i and turns each divided rising edge into a clk_i strobe
 */
`timescale 1ns/100ps
`default_nettype none

module rtc_tick (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic rtc_i,
  output logic tick_o
);

  logic                           rtc_div_q;
  logic [soc_pkg::SyncStages-1:0] sync_q;
  logic                           prev_q;

  always_ff @(posedge rtc_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_div_q <= 1'b0;
    end else begin
      rtc_div_q <= ~rtc_div_q;
    end
  end

  // Synchronizer followed by a registered edge detector
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      sync_q <= '0;
      prev_q <= 1'b0;
      tick_o <= 1'b0;
    end else begin
      sync_q <= {sync_q[soc_pkg::SyncStages-2:0], rtc_div_q};
      prev_q <= sync_q[soc_pkg::SyncStages-1];
      tick_o <= sync_q[soc_pkg::SyncStages-1] & ~prev_q;
    end
  end

endmodule

`default_nettype wire

// ==== design/clint/clint_regs.sv ====
/*
 * Core-local interruptor registers
 * mtime, per-hart mtimecmp and msip, timer and software interrupts
 */
`timescale 1ns/100ps
`default_nettype none

module clint_regs #(
  parameter int unsigned NumHarts = 2
) (
  input  logic                          clk_i,
  input  logic                          ndmreset_n,
  input  logic                          tick_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::AddrWidth-1:0] addr_i,
  input  logic [soc_pkg::DataWidth-1:0] wdata_i,
  output logic                          rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic                          err_o,
  output logic [NumHarts-1:0]           timer_irq_o,
  output logic [NumHarts-1:0]           ipi_o
);

  localparam int unsigned HartWidth = (NumHarts > 1) ? $clog2(NumHarts) : 1;
  localparam logic [soc_pkg::AddrWidth-1:0] MsipEnd =
    soc_pkg::ClintMsipOffset + 8 * NumHarts;
  localparam logic [soc_pkg::AddrWidth-1:0] CmpEnd =
    soc_pkg::ClintMtimecmpOffset + 8 * NumHarts;

  logic [soc_pkg::DataWidth-1:0]               mtime_q;
  logic [NumHarts-1:0][soc_pkg::DataWidth-1:0] mtimecmp_q;
  logic [NumHarts-1:0]                         msip_q;

  logic                          msip_hit, cmp_hit, mtime_hit, any_hit, wr_en;
  logic [soc_pkg::AddrWidth-1:0] rel_offset;
  logic [soc_pkg::AddrWidth-4:0] hart_word;
  logic [HartWidth-1:0]          hart;
  logic [soc_pkg::DataWidth-1:0] rd_val;

  // ------------------------------
  // Decode
  // ------------------------------
  assign msip_hit  = addr_i < MsipEnd;
  assign cmp_hit   = addr_i >= soc_pkg::ClintMtimecmpOffset && addr_i < CmpEnd;
  assign mtime_hit = addr_i == soc_pkg::ClintMtimeOffset;
  assign any_hit   = msip_hit | cmp_hit | mtime_hit;
  assign wr_en     = req_i & we_i;

  assign rel_offset = cmp_hit ? addr_i - soc_pkg::ClintMtimecmpOffset
                              : addr_i - soc_pkg::ClintMsipOffset;
  assign hart_word  = rel_offset[soc_pkg::AddrWidth-1:3];
  assign hart       = hart_word[HartWidth-1:0];

  always_comb begin
    rd_val = '0;
    if (msip_hit) begin
      rd_val[0] = msip_q[hart];
    end else if (cmp_hit) begin
      rd_val = mtimecmp_q[hart];
    end else if (mtime_hit) begin
      rd_val = mtime_q;
    end
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= '0;
      timer_irq_o <= '0;
    end else begin
      // Software write wins over the tick
      if (wr_en && mtime_hit) begin
        mtime_q <= wdata_i;
      end else if (tick_i) begin
        mtime_q <= mtime_q + 64'd1;
      end
      if (wr_en && cmp_hit) begin
        mtimecmp_q[hart] <= wdata_i;
      end
      if (wr_en && msip_hit) begin
        msip_q[hart] <= wdata_i[0];
      end
      for (int h = 0; h < NumHarts; h++) begin
        timer_irq_o[h] <= mtime_q >= mtimecmp_q[h];
      end
    end
  end

  assign ipi_o = msip_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_o <= 1'b0;
      err_o       <= 1'b0;
    end else begin
      rsp_valid_o <= req_i;
      err_o       <= req_i & ~any_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= (!we_i && any_hit) ? rd_val : '0;
    end
  end

  a_hart_in_range : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    req_i && (msip_hit || cmp_hit) |-> hart_word < NumHarts);

endmodule

`default_nettype wire

// ==== design/debug/debug_ctrl.sv ====
/*
 * Debug control block
 * Halt-request register and post-reset delay before debug requests
 */
`timescale 1ns/100ps
`default_nettype none

module debug_ctrl #(
  parameter int unsigned NumHarts     = 2,
  parameter int unsigned DmiDelCycles = 500
) (
  input  logic                          clk_i,
  input  logic                          ndmreset_n,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::AddrWidth-1:0] addr_i,
  input  logic [soc_pkg::DataWidth-1:0] wdata_i,
  output logic                          rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic                          err_o,
  output logic [NumHarts-1:0]           debug_req_o
);

  localparam int unsigned CntWidth = $clog2(DmiDelCycles + 1);

  logic [NumHarts-1:0] haltreq_q;
  logic [CntWidth-1:0] del_cnt_q;
  logic                hit;

  assign hit = addr_i == soc_pkg::DebugHaltreqOffset;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      haltreq_q   <= '0;
      del_cnt_q   <= CntWidth'(DmiDelCycles);
      rsp_valid_o <= 1'b0;
      err_o       <= 1'b0;
    end else begin
      if (req_i && we_i && hit) begin
        haltreq_q <= wdata_i[NumHarts-1:0];
      end
      if (del_cnt_q != '0) begin
        del_cnt_q <= del_cnt_q - 1'b1;
      end
      rsp_valid_o <= req_i;
      err_o       <= req_i & ~hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= (!we_i && hit) ? {{(soc_pkg::DataWidth - NumHarts){1'b0}}, haltreq_q} : '0;
    end
  end

  // Boot code runs before the first request reaches a hart
  assign debug_req_o = (del_cnt_q != '0) ? '0 : haltreq_q;

  a_cnt_bounded : assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    del_cnt_q <= DmiDelCycles);

endmodule

`default_nettype wire

// ==== design/rom/boot_rom.sv ====
/*
 * Boot ROM
 * Registered word reads from the package table, writes are rejected
 */
`timescale 1ns/100ps
`default_nettype none

module boot_rom (
  input  logic                          clk_i,
  input  logic                          ndmreset_n,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::AddrWidth-1:0] addr_i,
  output logic                          rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic                          err_o
);

  localparam int unsigned IdxWidth = $clog2(soc_pkg::RomWords);

  logic [soc_pkg::AddrWidth-4:0] word_idx;
  logic                          rd_ok;

  assign word_idx = addr_i[soc_pkg::AddrWidth-1:3];
  assign rd_ok    = !we_i && word_idx < soc_pkg::RomWords;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rsp_valid_o <= 1'b0;
      err_o       <= 1'b0;
    end else begin
      rsp_valid_o <= req_i;
      err_o       <= req_i & ~rd_ok;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_o <= rd_ok ? soc_pkg::boot_rom_content[word_idx[IdxWidth-1:0]] : '0;
    end
  end

endmodule

`default_nettype wire

// ==== design/soc_subsystem.sv ====
/*
 * Control subsystem top level
 * Connects the peripheral crossbar to debug control, boot ROM and interruptor
 */
`timescale 1ns/100ps
`default_nettype none

module soc_subsystem #(
  parameter int unsigned NumHarts     = 2,
  parameter int unsigned DmiDelCycles = 500
) (
  input  logic                          clk_i,
  input  logic                          ndmreset_n,
  input  logic                          rtc_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::AddrWidth-1:0] addr_i,
  input  logic [soc_pkg::DataWidth-1:0] wdata_i,
  output logic                          rsp_valid_o,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic                          err_o,
  output logic [NumHarts-1:0]           timer_irq_o,
  output logic [NumHarts-1:0]           ipi_o,
  output logic [NumHarts-1:0]           debug_req_o
);

  logic                          dbg_sel, rom_sel, clint_sel;
  logic                          tgt_we;
  logic [soc_pkg::AddrWidth-1:0] tgt_offset;
  logic [soc_pkg::DataWidth-1:0] tgt_wdata;

  logic                          dbg_rsp_valid, rom_rsp_valid, clint_rsp_valid;
  logic [soc_pkg::DataWidth-1:0] dbg_rdata, rom_rdata, clint_rdata;
  logic                          dbg_err, rom_err, clint_err;
  logic                          tick;

  periph_xbar i_periph_xbar (
    .clk_i             ( clk_i           ),
    .ndmreset_n        ( ndmreset_n      ),
    .req_i             ( req_i           ),
    .we_i              ( we_i            ),
    .addr_i            ( addr_i          ),
    .wdata_i           ( wdata_i         ),
    .rsp_valid_o       ( rsp_valid_o     ),
    .rdata_o           ( rdata_o         ),
    .err_o             ( err_o           ),
    .dbg_sel_o         ( dbg_sel         ),
    .rom_sel_o         ( rom_sel         ),
    .clint_sel_o       ( clint_sel       ),
    .tgt_we_o          ( tgt_we          ),
    .tgt_offset_o      ( tgt_offset      ),
    .tgt_wdata_o       ( tgt_wdata       ),
    .dbg_rsp_valid_i   ( dbg_rsp_valid   ),
    .dbg_rdata_i       ( dbg_rdata       ),
    .dbg_err_i         ( dbg_err         ),
    .rom_rsp_valid_i   ( rom_rsp_valid   ),
    .rom_rdata_i       ( rom_rdata       ),
    .rom_err_i         ( rom_err         ),
    .clint_rsp_valid_i ( clint_rsp_valid ),
    .clint_rdata_i     ( clint_rdata     ),
    .clint_err_i       ( clint_err       )
  );

  debug_ctrl #(
    .NumHarts     ( NumHarts     ),
    .DmiDelCycles ( DmiDelCycles )
  ) i_debug_ctrl (
    .clk_i       ( clk_i         ),
    .ndmreset_n  ( ndmreset_n    ),
    .req_i       ( dbg_sel       ),
    .we_i        ( tgt_we        ),
    .addr_i      ( tgt_offset    ),
    .wdata_i     ( tgt_wdata     ),
    .rsp_valid_o ( dbg_rsp_valid ),
    .rdata_o     ( dbg_rdata     ),
    .err_o       ( dbg_err       ),
    .debug_req_o ( debug_req_o   )
  );

  boot_rom i_boot_rom (
    .clk_i       ( clk_i         ),
    .ndmreset_n  ( ndmreset_n    ),
    .req_i       ( rom_sel       ),
    .we_i        ( tgt_we        ),
    .addr_i      ( tgt_offset    ),
    .rsp_valid_o ( rom_rsp_valid ),
    .rdata_o     ( rom_rdata     ),
    .err_o       ( rom_err       )
  );

  rtc_tick i_rtc_tick (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .rtc_i      ( rtc_i      ),
    .tick_o     ( tick       )
  );

  clint_regs #(
    .NumHarts ( NumHarts )
  ) i_clint_regs (
    .clk_i       ( clk_i           ),
    .ndmreset_n  ( ndmreset_n      ),
    .tick_i      ( tick            ),
    .req_i       ( clint_sel       ),
    .we_i        ( tgt_we          ),
    .addr_i      ( tgt_offset      ),
    .wdata_i     ( tgt_wdata       ),
    .rsp_valid_o ( clint_rsp_valid ),
    .rdata_o     ( clint_rdata     ),
    .err_o       ( clint_err       ),
    .timer_irq_o ( timer_irq_o     ),
    .ipi_o       ( ipi_o           )
  );

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
/*
 * Testbench clock generator
 * Free-running clock, starts low
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned PeriodNs = 10
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PeriodNs / 2) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_soc_subsystem.sv ====
/*
 * Control subsystem testbench
 * Table of bus accesses applied in a loop with responses checked two cycles later
 */
`timescale 1ns/100ps
`default_nettype none

module tb_soc_subsystem;

  localparam int unsigned NumHarts = 2;

  typedef struct packed {
    logic                          we;
    logic [soc_pkg::AddrWidth-1:0] addr;
    logic [soc_pkg::DataWidth-1:0] wdata;
    logic [soc_pkg::DataWidth-1:0] exp;
    logic                          err;
    logic                          ge;
  } entry_t;

  logic                          clk;
  logic                          ndmreset_n, rtc_i, req_i, we_i;
  logic [soc_pkg::AddrWidth-1:0] addr_i;
  logic [soc_pkg::DataWidth-1:0] wdata_i;
  logic                          rsp_valid_o, err_o;
  logic [soc_pkg::DataWidth-1:0] rdata_o;
  logic [NumHarts-1:0]           timer_irq_o, ipi_o, debug_req_o;

  entry_t      tbl [$];
  int          next_entry = 0;
  int          cyc = 0;
  int          rel_cyc = 0;
  bit          pipe_vld [3];
  int          pipe_idx [3];
  logic [31:0] lcg_state = 32'h054d_6c2a;

  tb_clk_gen #(.PeriodNs(10)) i_clk_gen (.clk_o(clk));

  soc_subsystem #(
    .NumHarts     ( NumHarts ),
    .DmiDelCycles ( 64       )
  ) UUT (
    .clk_i       ( clk         ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .wdata_i     ( wdata_i     ),
    .rsp_valid_o ( rsp_valid_o ),
    .rdata_o     ( rdata_o     ),
    .err_o       ( err_o       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o )
  );

  // Real-time clock with a 40 ns period
  always #20 rtc_i <= ~rtc_i;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= tbl.size() * 4 + 2000) begin
      $display("Timeout: the test did not finish within %0d cycles", cyc);
      $display("Simulation finished: FAIL");
      $fatal(1, "timeout");
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, actual, expected);
      $display("Simulation finished: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic bit in_map(input logic [31:0] a);
    return (a < 32'h0000_1000) ||
           (a >= 32'h0001_0000 && a < 32'h0001_1000) ||
           (a >= 32'h0200_0000 && a < 32'h0200_C000);
  endfunction

  task automatic add_entry(input bit we, input logic [31:0] addr, input logic [63:0] wdata,
                           input logic [63:0] exp, input bit err, input bit ge);
    entry_t e;
    e = '{we: we, addr: addr, wdata: wdata, exp: exp, err: err, ge: ge};
    tbl.push_back(e);
  endtask

  // One clock that optionally issues the next entry and checks the one from two cycles back
  task automatic cycle_step(input bit issue);
    entry_t e;
    @(posedge clk);
    if (issue) begin
      e = tbl[next_entry];
      req_i   <= 1'b1;
      we_i    <= e.we;
      addr_i  <= e.addr;
      wdata_i <= e.wdata;
    end else begin
      req_i <= 1'b0;
    end
    pipe_vld[2] = pipe_vld[1];
    pipe_idx[2] = pipe_idx[1];
    pipe_vld[1] = pipe_vld[0];
    pipe_idx[1] = pipe_idx[0];
    pipe_vld[0] = issue;
    pipe_idx[0] = next_entry;
    if (issue) begin
      next_entry++;
    end
    @(negedge clk);
    check_value(rsp_valid_o, pipe_vld[2], "rsp_valid_o");
    if (pipe_vld[2]) begin
      e = tbl[pipe_idx[2]];
      check_value(err_o, e.err, $sformatf("entry %0d err_o", pipe_idx[2]));
      if (e.ge) begin
        check_value(rdata_o >= e.exp, 1'b1, $sformatf("entry %0d rdata_o low", pipe_idx[2]));
      end else begin
        check_value(rdata_o, e.exp, $sformatf("entry %0d rdata_o", pipe_idx[2]));
      end
    end
  endtask

  // Back-to-back requests followed by a pipeline drain
  task automatic run_entries(input int n);
    repeat (n) cycle_step(1'b1);
    repeat (2) cycle_step(1'b0);
  endtask

  task automatic idle_until(input int n);
    while (cyc - rel_cyc < n) begin
      cycle_step(1'b0);
    end
  endtask

  initial begin
    logic [31:0] rnd_addr;
    int          waited;

    ndmreset_n = 1'b0;
    rtc_i      = 1'b0;
    req_i      = 1'b0;
    we_i       = 1'b0;
    addr_i     = '0;
    wdata_i    = '0;

    // Debug halt request and read back
    add_entry(1'b1, soc_pkg::DebugBase, 64'd3, 64'd0, 1'b0, 1'b0);
    add_entry(1'b0, soc_pkg::DebugBase, 64'd0, 64'd3, 1'b0, 1'b0);
    // Boot ROM
    for (int i = 0; i < 8; i++) begin
      add_entry(1'b0, soc_pkg::RomBase + 8 * i, 64'd0, 64'h0B00_7000_0000_0000 + i, 1'b0, 1'b0);
    end
    add_entry(1'b1, soc_pkg::RomBase, 64'h1234, 64'd0, 1'b1, 1'b0);
    add_entry(1'b0, soc_pkg::RomBase + 32'h40, 64'd0, 64'd0, 1'b1, 1'b0);
    // Unmapped addresses
    for (int i = 0; i < 6; i++) begin
      do begin
        lcg_state = lcg_next(lcg_state);
        rnd_addr  = {lcg_state[31:3], 3'b000};
      end while (in_map(rnd_addr));
      add_entry(i[0], rnd_addr, {32'd0, lcg_state}, 64'd0, 1'b1, 1'b0);
    end
    // Software interrupt of hart 1
    add_entry(1'b1, soc_pkg::ClintBase + 32'h8, 64'd1, 64'd0, 1'b0, 1'b0);
    add_entry(1'b0, soc_pkg::ClintBase + 32'h8, 64'd0, 64'd1, 1'b0, 1'b0);
    add_entry(1'b1, soc_pkg::ClintBase + 32'h8, 64'd0, 64'd0, 1'b0, 1'b0);
    // Timer
    add_entry(1'b1, soc_pkg::ClintBase + 32'hBFF8, 64'd1000, 64'd0, 1'b0, 1'b0);
    add_entry(1'b1, soc_pkg::ClintBase + 32'h4000, 64'd1003, 64'd0, 1'b0, 1'b0);
    add_entry(1'b0, soc_pkg::ClintBase + 32'hBFF8, 64'd0, 64'd1003, 1'b0, 1'b1);
    add_entry(1'b0, soc_pkg::ClintBase + 32'h4000, 64'd0, 64'd1003, 1'b0, 1'b0);
    add_entry(1'b0, soc_pkg::ClintBase + 32'h4008, 64'd0, '1, 1'b0, 1'b0);
    add_entry(1'b0, soc_pkg::ClintBase + 32'h8000, 64'd0, 64'd0, 1'b1, 1'b0);

    repeat (16) cycle_step(1'b0);
    @(posedge clk);
    ndmreset_n <= 1'b1;
    @(negedge clk);
    rel_cyc = cyc;
    check_value(timer_irq_o, 2'b00, "timer_irq_o after reset");
    check_value(ipi_o, 2'b00, "ipi_o after reset");
    check_value(debug_req_o, 2'b00, "debug_req_o after reset");

    // ------------------------------
    // Debug request gating
    // ------------------------------
    run_entries(1);
    idle_until(40);
    check_value(debug_req_o, 2'b00, "debug_req_o at cycle 40");
    idle_until(80);
    check_value(debug_req_o, 2'b11, "debug_req_o at cycle 80");
    run_entries(1);

    run_entries(10);
    run_entries(6);

    // ------------------------------
    // Software interrupts
    // ------------------------------
    run_entries(1);
    check_value(ipi_o, 2'b10, "ipi_o after msip set");
    run_entries(2);
    check_value(ipi_o, 2'b00, "ipi_o after msip clear");

    // ------------------------------
    // Timer
    // ------------------------------
    run_entries(2);
    // Compare sees the new mtimecmp one edge after its write
    cycle_step(1'b0);
    check_value(timer_irq_o[0], 1'b0, "timer_irq_o[0] before match");
    waited = 0;
    while (!timer_irq_o[0] && waited < 600) begin
      cycle_step(1'b0);
      waited++;
    end
    check_value(timer_irq_o[0], 1'b1, "timer_irq_o[0] within 600 cycles");
    check_value(timer_irq_o[1], 1'b0, "timer_irq_o[1]");
    run_entries(4);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/soc_pkg.sv
design/xbar/periph_xbar.sv
design/clint/rtc_tick.sv
design/clint/clint_regs.sv
design/debug/debug_ctrl.sv
design/rom/boot_rom.sv
design/soc_subsystem.sv
test/tb_clk_gen.sv
test/tb_soc_subsystem.sv

// ==== Makefile ====
# Verilator build and run for the control subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_soc_subsystem
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
